/* src/mem_map_pkg.sv */
// Bus widths, address windows, RAM depth and UART register constants for the data bus
package mem_map_pkg;

	// Core bus widths
	localparam int data_width = 32;
	localparam int addr_width = 32;

	// RAM window, end is exclusive
	localparam logic [addr_width-1:0] ram_base = 32'h1001_0000;
	localparam logic [addr_width-1:0] ram_end = 32'h1004_0000;

	// UART carve-out inside the RAM window, both bounds inclusive
	localparam logic [addr_width-1:0] uart_base = 32'h1001_0020;
	localparam logic [addr_width-1:0] uart_last = 32'h1001_0040;

	// Stack window starts at ram_end, top is exclusive
	localparam logic [addr_width-1:0] stack_top = 32'h7FFF_EFFC;
	// Byte offset in RAM that lines up with stack_top
	localparam logic [addr_width-1:0] stack_offset = 32'h0000_00D4;

	// Data RAM geometry in words
	localparam int ram_addr_width = 8;
	localparam int ram_depth = 256;

	// UART register index width and word offsets
	localparam int uart_reg_width = 4;
	localparam logic [uart_reg_width-1:0] uart_reg_tx = 4'd0;
	localparam logic [uart_reg_width-1:0] uart_reg_status = 4'd1;
	localparam logic [uart_reg_width-1:0] uart_reg_divisor = 4'd2;

	// Baud divisor, in clock cycles per bit
	localparam int divisor_width = 16;
	localparam logic [divisor_width-1:0] divisor_reset = 16'd8;

endpackage

/* src/memory_map.sv */
// Address decoder with slave selects, word index translation and read-data return mux
`timescale 1ns/1ns

module memory_map (
	// Core side
	input  logic [mem_map_pkg::addr_width-1:0]     address,
	input  logic [mem_map_pkg::data_width-1:0]     wd,
	input  logic                                   we,
	output logic [mem_map_pkg::data_width-1:0]     rd,
	// Data RAM side
	output logic                                   ram_sel,
	output logic                                   ram_we,
	output logic [mem_map_pkg::ram_addr_width-1:0] ram_addr,
	output logic [mem_map_pkg::data_width-1:0]     ram_wdata,
	input  logic [mem_map_pkg::data_width-1:0]     ram_rdata,
	// UART register side
	output logic                                   uart_sel,
	output logic                                   uart_we,
	output logic [mem_map_pkg::uart_reg_width-1:0] uart_addr,
	output logic [mem_map_pkg::data_width-1:0]     uart_wdata,
	input  logic [mem_map_pkg::data_width-1:0]     uart_rdata
);
	import mem_map_pkg::*;

	// Raw window compares
	logic in_ram_window;
	logic in_uart_window;
	logic in_stack_window;

	// Decoded target, at most one set
	logic hit_ram;
	logic hit_uart;
	logic hit_stack;

	// Byte offsets into each slave
	logic [addr_width-1:0] ram_byte;
	logic [addr_width-1:0] stack_byte;
	logic [addr_width-1:0] uart_byte;

	assign in_ram_window = (address >= ram_base) && (address < ram_end);
	assign in_uart_window = (address >= uart_base) && (address <= uart_last);
	// Stack sits directly above the RAM window
	assign in_stack_window = (address >= ram_end) && (address < stack_top);

	// UART carve-out wins inside the RAM window
	assign hit_uart = in_ram_window && in_uart_window;
	assign hit_ram = in_ram_window && !in_uart_window;
	assign hit_stack = in_stack_window;

	// Offset from window base
	assign ram_byte = address - ram_base;
	assign uart_byte = address - uart_base;
	// Stack grows down from stack_top, folded onto stack_offset in RAM
	assign stack_byte = address - stack_top + stack_offset;

	// Stack and RAM share one slave
	assign ram_sel = hit_ram || hit_stack;
	assign uart_sel = hit_uart;

	// Write strobes only reach the selected slave
	assign ram_we = ram_sel && we;
	assign uart_we = uart_sel && we;

	// Write data goes to both slaves, strobes decide
	assign ram_wdata = wd;
	assign uart_wdata = wd;

	// Word index per slave
	always_comb begin
		ram_addr = '0;
		uart_addr = '0;
		if (hit_stack) begin
			ram_addr = stack_byte[ram_addr_width+1:2];
		end else if (hit_ram) begin
			ram_addr = ram_byte[ram_addr_width+1:2];
		end
		if (hit_uart) begin
			uart_addr = uart_byte[uart_reg_width+1:2];
		end
	end

	// Read data return, same cycle as the address
	always_comb begin
		if (hit_uart) begin
			rd = uart_rdata;
		end else if (hit_ram || hit_stack) begin
			rd = ram_rdata;
		end else begin
			// Reserved space reads as zero
			rd = '0;
		end
	end

endmodule

/* src/data_ram.sv */
// Word-addressed data RAM with synchronous write and combinational read
`timescale 1ns/1ns

module data_ram (
	input  logic                                   clk,
	// Slave select and write strobe from the map
	input  logic                                   sel,
	input  logic                                   we,
	// Word index
	input  logic [mem_map_pkg::ram_addr_width-1:0] addr,
	input  logic [mem_map_pkg::data_width-1:0]     wdata,
	output logic [mem_map_pkg::data_width-1:0]     rdata
);
	import mem_map_pkg::*;

	// Storage array, contents undefined after power-up
	logic [data_width-1:0] mem [ram_depth];

	// Write lands at the edge, visible to reads the next cycle
	always_ff @(posedge clk) begin
		if (sel && we) begin
			mem[addr] <= wdata;
		end
	end

	// Asynchronous read port
	assign rdata = mem[addr];

endmodule

/* src/uart_regs.sv */
// UART register file with transmit launch, status readback and baud divisor
`timescale 1ns/1ns

module uart_regs (
	input  logic                                   clk,
	input  logic                                   reset,
	// Bus side from the map
	input  logic                                   sel,
	input  logic                                   we,
	input  logic [mem_map_pkg::uart_reg_width-1:0] addr,
	input  logic [mem_map_pkg::data_width-1:0]     wdata,
	output logic [mem_map_pkg::data_width-1:0]     rdata,
	// Transmitter side
	input  logic                                   tx_busy,
	output logic                                   tx_start,
	output logic [7:0]                             tx_data,
	output logic [mem_map_pkg::divisor_width-1:0]  divisor
);
	import mem_map_pkg::*;

	logic wr_en;
	logic tx_accept;

	assign wr_en = sel && we;

	// Launch only when the transmitter is idle
	// Pending pulse also blocks, busy has not risen yet
	assign tx_accept = wr_en && (addr == uart_reg_tx) && !tx_busy && !tx_start;

	// Control registers
	always_ff @(posedge clk) begin
		if (reset) begin
			tx_start <= 1'b0;
			divisor <= divisor_reset;
		end else begin
			// One-cycle pulse after an accepted write
			tx_start <= tx_accept;
			if (wr_en && (addr == uart_reg_divisor)) begin
				divisor <= wdata[divisor_width-1:0];
			end
		end
	end

	// Byte held for the frame and for readback
	always_ff @(posedge clk) begin
		if (tx_accept) begin
			tx_data <= wdata[7:0];
		end
	end

	// Register readback
	always_comb begin
		rdata = '0;
		case (addr)
			uart_reg_tx: rdata[7:0] = tx_data;
			// Bit 0 is the only status flag
			uart_reg_status: rdata[0] = tx_busy;
			uart_reg_divisor: rdata[divisor_width-1:0] = divisor;
			default: rdata = '0;
		endcase
	end

endmodule

/* src/uart_tx.sv */
// 8N1 serial transmitter with baud counter and frame shift register
`timescale 1ns/1ns

module uart_tx (
	input  logic                                  clk,
	input  logic                                  reset,
	// Launch pulse and byte from the register file
	input  logic                                  tx_start,
	input  logic [7:0]                            tx_data,
	// Cycles per bit
	input  logic [mem_map_pkg::divisor_width-1:0] divisor,
	// Serial line, idles high
	output logic                                  tx,
	output logic                                  tx_busy
);
	import mem_map_pkg::*;

	// Frame shifts out LSB first, ones fill in from the top
	logic [9:0] frame;
	// Cycles left in the current bit
	logic [divisor_width-1:0] baud_cnt;
	// Bits left after the current one
	logic [3:0] bit_cnt;
	logic busy;

	always_ff @(posedge clk) begin
		if (reset) begin
			frame <= '1;
			baud_cnt <= '0;
			bit_cnt <= '0;
			busy <= 1'b0;
		end else if (!busy) begin
			if (tx_start) begin
				// Stop bit, data, start bit
				frame <= {1'b1, tx_data, 1'b0};
				baud_cnt <= divisor - 1'b1;
				bit_cnt <= 4'($bits(frame) - 1);
				busy <= 1'b1;
			end
		end else if (baud_cnt != '0) begin
			baud_cnt <= baud_cnt - 1'b1;
		end else if (bit_cnt != '0) begin
			// Next bit onto the line
			frame <= {1'b1, frame[9:1]};
			baud_cnt <= divisor - 1'b1;
			bit_cnt <= bit_cnt - 1'b1;
		end else begin
			// End of stop bit
			// Line already high, nothing to shift
			busy <= 1'b0;
		end
	end

	// Line driven straight from the frame flop
	assign tx = frame[0];
	assign tx_busy = busy;

endmodule

/* src/data_bus_top.sv */
// Data bus top level joining the memory map, data RAM, UART registers and transmitter
`timescale 1ns/1ns

module data_bus_top (
	input  logic                               clk,
	input  logic                               reset,
	// Core data bus
	input  logic [mem_map_pkg::addr_width-1:0] address,
	input  logic [mem_map_pkg::data_width-1:0] wd,
	input  logic                               we,
	output logic [mem_map_pkg::data_width-1:0] rd,
	// Serial output
	output logic                               tx
);
	import mem_map_pkg::*;

	// Map to RAM
	logic                      ram_sel;
	logic                      ram_we;
	logic [ram_addr_width-1:0] ram_addr;
	logic [data_width-1:0]     ram_wdata;
	logic [data_width-1:0]     ram_rdata;

	// Map to UART registers
	logic                      uart_sel;
	logic                      uart_we;
	logic [uart_reg_width-1:0] uart_addr;
	logic [data_width-1:0]     uart_wdata;
	logic [data_width-1:0]     uart_rdata;

	// Registers to transmitter
	logic                      tx_start;
	logic [7:0]                tx_data;
	logic [divisor_width-1:0]  divisor;
	logic                      tx_busy;

	memory_map i_memory_map (
		.address    (address),
		.wd         (wd),
		.we         (we),
		.rd         (rd),
		.ram_sel    (ram_sel),
		.ram_we     (ram_we),
		.ram_addr   (ram_addr),
		.ram_wdata  (ram_wdata),
		.ram_rdata  (ram_rdata),
		.uart_sel   (uart_sel),
		.uart_we    (uart_we),
		.uart_addr  (uart_addr),
		.uart_wdata (uart_wdata),
		.uart_rdata (uart_rdata)
	);

	// RAM write strobe already qualified by the map
	data_ram i_data_ram (
		.clk   (clk),
		.sel   (ram_sel),
		.we    (ram_we),
		.addr  (ram_addr),
		.wdata (ram_wdata),
		.rdata (ram_rdata)
	);

	uart_regs i_uart_regs (
		.clk      (clk),
		.reset    (reset),
		.sel      (uart_sel),
		.we       (uart_we),
		.addr     (uart_addr),
		.wdata    (uart_wdata),
		.rdata    (uart_rdata),
		.tx_busy  (tx_busy),
		.tx_start (tx_start),
		.tx_data  (tx_data),
		.divisor  (divisor)
	);

	uart_tx i_uart_tx (
		.clk      (clk),
		.reset    (reset),
		.tx_start (tx_start),
		.tx_data  (tx_data),
		.divisor  (divisor),
		.tx       (tx),
		.tx_busy  (tx_busy)
	);

endmodule

/* sim/tb_data_bus.sv */
// Directed testbench for the data bus with LFSR data, bus tasks, compare tasks and frame checks
`timescale 1ns/1ns

module tb_data_bus;
	import mem_map_pkg::*;

	// Programmed baud divisor, even so the bit middle falls on a cycle
	localparam int baud = 12;
	localparam int timeout_cycles = 64;
	localparam logic [addr_width-1:0] tx_addr = uart_base + {26'b0, uart_reg_tx, 2'b00};
	localparam logic [addr_width-1:0] status_addr = uart_base + {26'b0, uart_reg_status, 2'b00};
	localparam logic [addr_width-1:0] div_addr = uart_base + {26'b0, uart_reg_divisor, 2'b00};
	localparam logic [addr_width-1:0] reserved_addr = 32'h8000_0000;
	// RAM offsets with distinct word indices, clear of the UART carve-out and index 0x34
	localparam logic [addr_width-1:0] ram_offsets [5] = '{
		32'h0000_0000, 32'h0000_0004, 32'h0000_0010, 32'h0000_01F0, 32'h0002_FF00
	};

	logic clk;
	logic reset;
	logic [addr_width-1:0] address;
	logic [data_width-1:0] wd;
	logic we;
	logic [data_width-1:0] rd;
	logic tx;

	logic [31:0] lfsr;
	// Words written in the RAM test, rechecked by the reserved test
	logic [data_width-1:0] ram_words [5];
	int errors;
	int checks;
	int test_errors;

	data_bus_top i_data_bus_top (
		.clk     (clk),
		.reset   (reset),
		.address (address),
		.wd      (wd),
		.we      (we),
		.rd      (rd),
		.tx      (tx)
	);

	always #5 clk = ~clk;

	// Taps 32 22 2 1, one step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		logic fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			v = {v[30:0], fb};
		end
		return v;
	endfunction

	task automatic compare_word(input string name, input logic [data_width-1:0] got,
			input logic [data_width-1:0] exp);
		checks++;
		if (got !== exp) begin
			$display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
			errors++;
			test_errors++;
		end
	endtask

	task automatic compare_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			$display("ERROR %0t %s got %b expected %b", $time, name, got, exp);
			errors++;
			test_errors++;
		end
	endtask

	task automatic report_timeout(input string msg);
		$display("%s", msg);
		errors++;
		test_errors++;
	endtask

	task automatic end_test(input string name);
		$display("test %s finished with %0d errors", name, test_errors);
		test_errors = 0;
	endtask

	// One write strobe across a single rising edge
	task automatic bus_write(input logic [addr_width-1:0] a, input logic [data_width-1:0] d);
		@(negedge clk);
		address = a;
		wd = d;
		we = 1'b1;
		@(negedge clk);
		we = 1'b0;
	endtask

	// Read data settles by the next falling edge
	task automatic read_check(input string name, input logic [addr_width-1:0] a,
			input logic [data_width-1:0] exp);
		@(negedge clk);
		address = a;
		we = 1'b0;
		@(negedge clk);
		compare_word(name, rd, exp);
	endtask

	// Also drops a pending write strobe and parks the bus on status
	task automatic skip_cycles(input int n);
		repeat (n) begin
			@(negedge clk);
			we = 1'b0;
			address = status_addr;
		end
	endtask

	task automatic wait_tx_low(output logic seen);
		int n;
		seen = 1'b0;
		for (n = 0; n < timeout_cycles; n++) begin
			@(negedge clk);
			if (tx === 1'b0) begin
				seen = 1'b1;
				return;
			end
		end
		report_timeout("timeout: the start bit never appeared on tx");
	endtask

	task automatic wait_idle();
		int n;
		for (n = 0; n < 4 * baud; n++) begin
			@(negedge clk);
			if (rd[0] === 1'b0) return;
		end
		report_timeout("timeout: status busy never cleared after the frame");
	endtask

	// Samples each bit in its middle, optionally writing a second byte mid-frame
	task automatic check_frame(input logic [7:0] exp, input logic inject,
			input logic [7:0] second);
		logic started;
		address = status_addr;
		wait_tx_low(started);
		if (!started) return;
		compare_bit("status busy", rd[0], 1'b1);
		if (inject) begin
			address = tx_addr;
			wd = {24'b0, second};
			we = 1'b1;
		end
		skip_cycles(baud / 2);
		compare_bit("tx start bit", tx, 1'b0);
		for (int i = 0; i < 8; i++) begin
			skip_cycles(baud);
			compare_bit($sformatf("tx data bit %0d", i), tx, exp[i]);
		end
		skip_cycles(baud);
		compare_bit("tx stop bit", tx, 1'b1);
		wait_idle();
		read_check("status", status_addr, '0);
	endtask

	task automatic test_ram();
		for (int i = 0; i < 5; i++) begin
			ram_words[i] = rand_bits(32);
			bus_write(ram_base + ram_offsets[i], ram_words[i]);
		end
		for (int i = 0; i < 5; i++) begin
			read_check($sformatf("ram word %0d", i), ram_base + ram_offsets[i], ram_words[i]);
		end
		end_test("ram");
	endtask

	task automatic test_stack();
		logic [data_width-1:0] v;
		v = rand_bits(32);
		bus_write(stack_top - 32'd4, v);
		// Same word index 0x34 from both windows
		read_check("stack word", stack_top - 32'd4, v);
		read_check("stack alias", ram_base + stack_offset - 32'd4, v);
		end_test("stack");
	endtask

	task automatic test_uart_regs();
		logic [data_width-1:0] v;
		read_check("divisor after reset", div_addr, {16'b0, divisor_reset});
		read_check("status after reset", status_addr, '0);
		// Index 10 sits under the divisor address, reached here through the wrap alias
		v = rand_bits(32);
		bus_write(ram_base + 32'h428, v);
		bus_write(div_addr, 32'(baud));
		read_check("divisor", div_addr, 32'(baud));
		read_check("ram under uart", ram_base + 32'h428, v);
		end_test("uart_regs");
	endtask

	task automatic test_frame();
		logic [7:0] b;
		b = 8'(rand_bits(8));
		bus_write(tx_addr, {24'b0, b});
		check_frame(b, 1'b0, 8'h00);
		end_test("frame");
	endtask

	task automatic test_busy_drop();
		logic [7:0] first;
		logic [7:0] second;
		logic stayed_high;
		first = 8'(rand_bits(8));
		second = ~first;
		bus_write(tx_addr, {24'b0, first});
		check_frame(first, 1'b1, second);
		// A second frame would start within a few cycles
		stayed_high = 1'b1;
		repeat (2 * baud) begin
			@(negedge clk);
			stayed_high = stayed_high & tx;
		end
		compare_bit("tx idle after stop", stayed_high, 1'b1);
		read_check("tx data register", tx_addr, {24'b0, first});
		end_test("busy_drop");
	endtask

	task automatic test_reserved();
		bus_write(reserved_addr, rand_bits(32));
		for (int i = 0; i < 5; i++) begin
			read_check($sformatf("ram word %0d", i), ram_base + ram_offsets[i], ram_words[i]);
		end
		read_check("reserved read", reserved_addr, '0);
		end_test("reserved");
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		address = '0;
		wd = '0;
		we = 1'b0;
		lfsr = 32'h8deb6d96;
		errors = 0;
		checks = 0;
		test_errors = 0;
		repeat (3) @(negedge clk);
		reset = 1'b0;
		test_ram();
		test_stack();
		test_uart_regs();
		test_frame();
		test_busy_drop();
		test_reserved();
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

/* src.f */
src/mem_map_pkg.sv
src/memory_map.sv
src/data_ram.sv
src/uart_regs.sv
src/uart_tx.sv
src/data_bus_top.sv
sim/tb_data_bus.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --top-module tb_data_bus -f src.f -o tb_data_bus
	@out=$$(./obj_dir/tb_data_bus); echo "$$out"; echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf obj_dir
